// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_cpu_top
FILELIST  := rv32_multicycle.f

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// ==== alu_exec.sv ====
module alu_exec (
    input  cpu_pkg::insn_class_e     cls,
    input  cpu_pkg::alu_op_e         alu_op,
    input  logic [cpu_pkg::XLEN-1:0] imm,
    input  logic [cpu_pkg::XLEN-1:0] rs1_val,
    input  logic [cpu_pkg::XLEN-1:0] rs2_val,
    input  logic [cpu_pkg::XLEN-1:0] pc,
    output logic [cpu_pkg::XLEN-1:0] alu_result,
    output logic [cpu_pkg::XLEN-1:0] mem_addr,
    output logic                     branch_taken,
    output logic [cpu_pkg::XLEN-1:0] next_pc
);
    import cpu_pkg::*;

    logic [XLEN-1:0] operand_b;
    logic            use_rs2;
    logic            result_zero;

    // register operand for op and branch, immediate otherwise
    assign use_rs2   = (cls == CLS_ALU_REG) || (cls == CLS_BRANCH);
    assign operand_b = use_rs2 ? rs2_val : imm;

    // ==============================
    // alu
    // ==============================
    always_comb begin
        case (alu_op)
            ADD:     alu_result = rs1_val + operand_b;
            SUB:     alu_result = rs1_val - operand_b;
            AND:     alu_result = rs1_val & operand_b;
            OR:      alu_result = rs1_val | operand_b;
            XOR:     alu_result = rs1_val ^ operand_b;
            PASS_B:  alu_result = operand_b;
            default: alu_result = '0;
        endcase
    end

    assign result_zero = (alu_result == '0);

    // lw and sw address, byte granular
    assign mem_addr = rs1_val + imm;

    // ==============================
    // branch and next pc
    // ==============================
    // sub marks beq, xor marks bne
    assign branch_taken = (cls == CLS_BRANCH) && (result_zero == (alu_op == SUB));

    assign next_pc = branch_taken ? pc + imm : pc + XLEN'(4);

endmodule

// ==== core_sequencer.sv ====
module core_sequencer (
    input  logic                          sys_clk,
    input  logic                          sys_rst,
    input  logic                          run,
    input  logic                          prog_we,
    input  logic [cpu_pkg::MEM_IDX_W-1:0] prog_addr,
    input  logic [cpu_pkg::XLEN-1:0]      prog_data,
    input  logic [cpu_pkg::XLEN-1:0]      mem_rdata,
    input  cpu_pkg::insn_class_e          cls,
    input  logic [cpu_pkg::REG_IDX_W-1:0] rd,
    input  logic [cpu_pkg::XLEN-1:0]      rs2_val,
    input  logic [cpu_pkg::XLEN-1:0]      alu_result,
    input  logic [cpu_pkg::XLEN-1:0]      mem_addr,
    input  logic [cpu_pkg::XLEN-1:0]      next_pc,
    output logic                          mem_en,
    output logic                          mem_we,
    output logic [cpu_pkg::MEM_IDX_W-1:0] mem_idx,
    output logic [cpu_pkg::XLEN-1:0]      mem_wdata,
    output logic [cpu_pkg::XLEN-1:0]      insn,
    output logic [cpu_pkg::XLEN-1:0]      pc,
    output logic                          rf_we,
    output logic [cpu_pkg::REG_IDX_W-1:0] rf_waddr,
    output logic [cpu_pkg::XLEN-1:0]      rf_wdata,
    output logic                          retire_valid,
    output logic [cpu_pkg::XLEN-1:0]      retire_pc,
    output logic                          mem_we_out,
    output logic [cpu_pkg::XLEN-1:0]      mem_addr_out,
    output logic [cpu_pkg::XLEN-1:0]      mem_wdata_out
);
    import cpu_pkg::*;

    cpu_state_e      state;
    logic [XLEN-1:0] load_data;
    logic            is_mem_op;
    logic            writes_rd;

    assign is_mem_op = (cls == CLS_LOAD) || (cls == CLS_STORE);
    assign writes_rd = (cls == CLS_ALU_IMM) || (cls == CLS_ALU_REG)
                    || (cls == CLS_LOAD) || (cls == CLS_LUI);

    // ==============================
    // state machine
    // ==============================
    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            state <= FETCH;
        end else begin
            case (state)
                FETCH: begin
                    if (run) begin
                        state <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: state <= DECODE;
                DECODE:     state <= EXEC;
                EXEC:       state <= is_mem_op ? MEM : WRITEBACK;
                MEM:        state <= (cls == CLS_LOAD) ? MEM_WAIT : WRITEBACK;
                MEM_WAIT:   state <= WRITEBACK;
                default:    state <= FETCH;
            endcase
        end
    end

    // instruction latch and pc update
    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            pc   <= '0;
            insn <= '0;
        end else begin
            if (state == FETCH_WAIT) begin
                insn <= mem_rdata;
            end
            if (state == WRITEBACK) begin
                pc <= next_pc;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == MEM_WAIT) begin
            load_data <= mem_rdata;
        end
    end

    // ==============================
    // memory port
    // ==============================
    // idle fetch with run low hands the port to program load
    always_comb begin
        mem_en    = 1'b0;
        mem_we    = 1'b0;
        mem_idx   = pc[MEM_IDX_W+1:2];
        mem_wdata = prog_data;
        case (state)
            FETCH: begin
                if (run) begin
                    mem_en = 1'b1;
                end else begin
                    mem_en  = prog_we;
                    mem_we  = prog_we;
                    mem_idx = prog_addr;
                end
            end
            MEM: begin
                mem_en    = 1'b1;
                mem_we    = (cls == CLS_STORE);
                mem_idx   = mem_addr[MEM_IDX_W+1:2];
                mem_wdata = rs2_val;
            end
            default: begin
                mem_en = 1'b0;
            end
        endcase
    end

    // write-back and retire
    assign retire_valid = (state == WRITEBACK);
    assign retire_pc    = pc;
    assign rf_we        = retire_valid && writes_rd && (rd != '0);
    assign rf_waddr     = rd;
    assign rf_wdata     = (cls == CLS_LOAD) ? load_data : alu_result;

    assign mem_we_out    = (state == MEM) && (cls == CLS_STORE);
    assign mem_addr_out  = mem_addr;
    assign mem_wdata_out = rs2_val;

    // the state before a retire depends on the class being retired
    assert property (@(posedge sys_clk) disable iff (sys_rst)
        retire_valid |-> $past(state) == ((cls == CLS_LOAD)  ? MEM_WAIT :
                                          (cls == CLS_STORE) ? MEM : EXEC))
        else $error("core_sequencer: retire at pc %h after wrong state", pc);

endmodule

// ==== cpu_pkg.sv ====
package cpu_pkg;

    // ==============================
    // widths and sizes
    // ==============================
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int REG_COUNT = 32;
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = 8;

    // ==============================
    // rv32i encodings
    // ==============================
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_SW  = 3'b010;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // sequencer states
    typedef enum logic [2:0] {
        FETCH,
        FETCH_WAIT,
        DECODE,
        EXEC,
        MEM,
        MEM_WAIT,
        WRITEBACK
    } cpu_state_e;

    typedef enum logic [2:0] {
        CLS_ALU_IMM,
        CLS_ALU_REG,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_LUI,
        CLS_NOP
    } insn_class_e;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        PASS_B
    } alu_op_e;

endpackage

// ==== cpu_top.sv ====
module cpu_top (
    input  logic                          sys_clk,
    input  logic                          sys_rst,
    input  logic                          run,
    input  logic                          prog_we,
    input  logic [cpu_pkg::MEM_IDX_W-1:0] prog_addr,
    input  logic [cpu_pkg::XLEN-1:0]      prog_data,
    output logic                          retire_valid,
    output logic [cpu_pkg::XLEN-1:0]      retire_pc,
    output logic                          rd_we,
    output logic [cpu_pkg::REG_IDX_W-1:0] rd_idx,
    output logic [cpu_pkg::XLEN-1:0]      rd_data,
    output logic                          mem_we_out,
    output logic [cpu_pkg::XLEN-1:0]      mem_addr_out,
    output logic [cpu_pkg::XLEN-1:0]      mem_wdata_out
);
    import cpu_pkg::*;

    // decode and register read
    logic [XLEN-1:0]      insn;
    logic [XLEN-1:0]      pc;
    insn_class_e          cls;
    alu_op_e              alu_op;
    logic [REG_IDX_W-1:0] rs1;
    logic [REG_IDX_W-1:0] rs2;
    logic [REG_IDX_W-1:0] rd;
    logic [XLEN-1:0]      imm;
    logic [XLEN-1:0]      rs1_val;
    logic [XLEN-1:0]      rs2_val;

    // execute
    logic [XLEN-1:0]      alu_result;
    logic [XLEN-1:0]      mem_addr;
    logic [XLEN-1:0]      next_pc;

    // memory port
    logic                 mem_en;
    logic                 mem_we;
    logic [MEM_IDX_W-1:0] mem_idx;
    logic [XLEN-1:0]      mem_wdata;
    logic [XLEN-1:0]      mem_rdata;

    core_sequencer u_core_sequencer (
        .sys_clk       (sys_clk),
        .sys_rst       (sys_rst),
        .run           (run),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .mem_rdata     (mem_rdata),
        .cls           (cls),
        .rd            (rd),
        .rs2_val       (rs2_val),
        .alu_result    (alu_result),
        .mem_addr      (mem_addr),
        .next_pc       (next_pc),
        .mem_en        (mem_en),
        .mem_we        (mem_we),
        .mem_idx       (mem_idx),
        .mem_wdata     (mem_wdata),
        .insn          (insn),
        .pc            (pc),
        .rf_we         (rd_we),
        .rf_waddr      (rd_idx),
        .rf_wdata      (rd_data),
        .retire_valid  (retire_valid),
        .retire_pc     (retire_pc),
        .mem_we_out    (mem_we_out),
        .mem_addr_out  (mem_addr_out),
        .mem_wdata_out (mem_wdata_out)
    );

    insn_decode u_insn_decode (
        .insn   (insn),
        .cls    (cls),
        .alu_op (alu_op),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .imm    (imm)
    );

    reg_file u_reg_file (
        .sys_clk (sys_clk),
        .sys_rst (sys_rst),
        .raddr_a (rs1),
        .raddr_b (rs2),
        .we      (rd_we),
        .waddr   (rd_idx),
        .wdata   (rd_data),
        .rdata_a (rs1_val),
        .rdata_b (rs2_val)
    );

    unified_mem u_unified_mem (
        .sys_clk   (sys_clk),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_idx   (mem_idx),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    // taken flag is already folded into next_pc
    alu_exec u_alu_exec (
        .cls          (cls),
        .alu_op       (alu_op),
        .imm          (imm),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .pc           (pc),
        .alu_result   (alu_result),
        .mem_addr     (mem_addr),
        .branch_taken (),
        .next_pc      (next_pc)
    );

endmodule

// ==== insn_decode.sv ====
module insn_decode (
    input  logic [cpu_pkg::XLEN-1:0]      insn,
    output cpu_pkg::insn_class_e          cls,
    output cpu_pkg::alu_op_e              alu_op,
    output logic [cpu_pkg::REG_IDX_W-1:0] rs1,
    output logic [cpu_pkg::REG_IDX_W-1:0] rs2,
    output logic [cpu_pkg::REG_IDX_W-1:0] rd,
    output logic [cpu_pkg::XLEN-1:0]      imm
);
    import cpu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = insn[6:0];
    assign funct3 = insn[14:12];
    assign funct7 = insn[31:25];
    assign rs1    = insn[19:15];
    assign rs2    = insn[24:20];
    assign rd     = insn[11:7];

    // anything outside the kept set falls through as a nop
    always_comb begin
        cls    = CLS_NOP;
        alu_op = ADD;
        case (opcode)
            OPC_OP_IMM: begin
                cls = CLS_ALU_IMM;
                case (funct3)
                    F3_ADD:  alu_op = ADD;
                    F3_XOR:  alu_op = XOR;
                    F3_OR:   alu_op = OR;
                    F3_AND:  alu_op = AND;
                    default: cls = CLS_NOP;
                endcase
            end
            OPC_OP: begin
                cls = CLS_ALU_REG;
                if (funct7 == F7_SUB && funct3 == F3_ADD) begin
                    alu_op = SUB;
                end else if (funct7 != F7_BASE) begin
                    cls = CLS_NOP;
                end else begin
                    case (funct3)
                        F3_ADD:  alu_op = ADD;
                        F3_XOR:  alu_op = XOR;
                        F3_OR:   alu_op = OR;
                        F3_AND:  alu_op = AND;
                        default: cls = CLS_NOP;
                    endcase
                end
            end
            OPC_LOAD: begin
                if (funct3 == F3_LW) begin
                    cls = CLS_LOAD;
                end
            end
            OPC_STORE: begin
                if (funct3 == F3_SW) begin
                    cls = CLS_STORE;
                end
            end
            // beq uses sub, bne uses xor; both are zero only on equal operands
            OPC_BRANCH: begin
                if (funct3 == F3_BEQ) begin
                    cls    = CLS_BRANCH;
                    alu_op = SUB;
                end else if (funct3 == F3_BNE) begin
                    cls    = CLS_BRANCH;
                    alu_op = XOR;
                end
            end
            OPC_LUI: begin
                cls    = CLS_LUI;
                alu_op = PASS_B;
            end
            default: begin
                cls = CLS_NOP;
            end
        endcase
    end

    // immediate format by class
    always_comb begin
        case (cls)
            CLS_ALU_IMM, CLS_LOAD: imm = {{20{insn[31]}}, insn[31:20]};
            CLS_STORE:  imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
            CLS_BRANCH: imm = {{19{insn[31]}}, insn[31], insn[7], insn[30:25],
                               insn[11:8], 1'b0};
            CLS_LUI:    imm = {insn[31:12], 12'b0};
            default:    imm = '0;
        endcase
    end

endmodule

// ==== reg_file.sv ====
module reg_file (
    input  logic                          sys_clk,
    input  logic                          sys_rst,
    input  logic [cpu_pkg::REG_IDX_W-1:0] raddr_a,
    input  logic [cpu_pkg::REG_IDX_W-1:0] raddr_b,
    input  logic                          we,
    input  logic [cpu_pkg::REG_IDX_W-1:0] waddr,
    input  logic [cpu_pkg::XLEN-1:0]      wdata,
    output logic [cpu_pkg::XLEN-1:0]      rdata_a,
    output logic [cpu_pkg::XLEN-1:0]      rdata_b
);
    import cpu_pkg::*;

    logic [XLEN-1:0] regs [REG_COUNT];

    // x0 is never written, so it keeps its reset value
    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    assert property (@(posedge sys_clk) disable iff (sys_rst)
        (raddr_a == '0 |-> rdata_a == '0) and (raddr_b == '0 |-> rdata_b == '0))
        else $error("reg_file: x0 read as nonzero");

endmodule

// ==== rv32_multicycle.f ====
cpu_pkg.sv
insn_decode.sv
reg_file.sv
unified_mem.sv
alu_exec.sv
core_sequencer.sv
cpu_top.sv
tb_cpu_top.sv

// ==== tb_cpu_top.sv ====
module tb_cpu_top;
    import cpu_pkg::*;

    logic                 sys_clk;
    logic                 sys_rst;
    logic                 run;
    logic                 prog_we;
    logic [MEM_IDX_W-1:0] prog_addr;
    logic [XLEN-1:0]      prog_data;
    logic                 retire_valid;
    logic [XLEN-1:0]      retire_pc;
    logic                 rd_we;
    logic [REG_IDX_W-1:0] rd_idx;
    logic [XLEN-1:0]      rd_data;
    logic                 mem_we_out;
    logic [XLEN-1:0]      mem_addr_out;
    logic [XLEN-1:0]      mem_wdata_out;

    logic [31:0] lfsr = 32'd21;
    logic [31:0] prog [$];
    logic [31:0] end_pc;

    // reference model state
    logic [XLEN-1:0] model_regs [REG_COUNT];
    logic [XLEN-1:0] model_mem [MEM_WORDS];
    logic [XLEN-1:0] model_pc;
    logic            store_seen;

    logic [XLEN-1:0] m_insn, m_rs1v, m_rs2v, m_imm_i, m_imm_s, m_imm_b, m_ld_addr;
    logic [2:0]      m_f3;
    logic            m_alu_f3;
    logic [XLEN-1:0] exp_pc, exp_rd_data, exp_st_addr, exp_st_data, exp_next_pc;
    logic [4:0]      exp_rd_idx;
    logic            exp_rd_we, exp_store;

    cpu_top u_cpu_top (
        .sys_clk       (sys_clk),
        .sys_rst       (sys_rst),
        .run           (run),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .retire_valid  (retire_valid),
        .retire_pc     (retire_pc),
        .rd_we         (rd_we),
        .rd_idx        (rd_idx),
        .rd_data       (rd_data),
        .mem_we_out    (mem_we_out),
        .mem_addr_out  (mem_addr_out),
        .mem_wdata_out (mem_wdata_out)
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    task abort_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = galois_step(lfsr);
        end
    endtask

    // ==============================
    // instruction encoders
    // ==============================
    function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] imm, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    task build_program();
        logic [31:0] v;
        logic [2:0]  kind;
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] imm;
        logic [31:0] word;
        for (int r = 1; r < 8; r++) begin
            draw_bits(12, v);
            prog.push_back(itype_word(v[11:0], 5'd0, F3_ADD, 5'(r), OPC_OP_IMM));
        end
        // write to x0 is dropped, then x0 feeds an add
        prog.push_back(itype_word(12'd5, 5'd1, F3_ADD, 5'd0, OPC_OP_IMM));
        prog.push_back(rtype_word(F7_BASE, 5'd3, 5'd0, F3_ADD, 5'd2));
        // one fixed lui and one fixed jal, outside the kept set
        prog.push_back({20'habcde, 5'd3, OPC_LUI});
        prog.push_back({20'h00100, 5'd4, 7'b1101111});
        for (int n = 0; n < 24; n++) begin
            draw_bits(3, v);
            kind = v[2:0];
            draw_bits(3, v);
            rd = {2'b00, v[2:0]};
            draw_bits(3, v);
            rs1 = {2'b00, v[2:0]};
            draw_bits(3, v);
            rs2 = {2'b00, v[2:0]};
            draw_bits(12, v);
            imm = v[11:0];
            case (kind)
                3'd0: word = itype_word(imm, rs1, F3_ADD, rd, OPC_OP_IMM);
                3'd1: word = itype_word(imm, rs1, F3_AND, rd, OPC_OP_IMM);
                3'd2: word = itype_word(imm, rs1, F3_OR, rd, OPC_OP_IMM);
                3'd3: word = itype_word(imm, rs1, F3_XOR, rd, OPC_OP_IMM);
                3'd4: word = rtype_word(imm[0] ? F7_SUB : F7_BASE, rs2, rs1, F3_ADD, rd);
                3'd5: word = rtype_word(F7_BASE, rs2, rs1,
                                        imm[1] ? F3_OR : (imm[0] ? F3_AND : F3_XOR), rd);
                3'd6: word = {imm, imm[7:0], rd, OPC_LUI};
                // jal, outside the kept set
                default: word = {imm, imm[7:0], rd, 7'b1101111};
            endcase
            prog.push_back(word);
        end
        // store then load back, data region from word 128
        for (int k = 0; k < 4; k++) begin
            draw_bits(3, v);
            rs2 = {2'b00, v[2:0]};
            draw_bits(3, v);
            rd = {2'b00, v[2:0]};
            prog.push_back(store_word(12'(512 + 4 * k), rs2, 5'd0));
            prog.push_back(itype_word(12'(512 + 4 * k), 5'd0, F3_LW, rd, OPC_LOAD));
        end
        // each branch skips one addi when taken
        prog.push_back(branch_word(13'd8, 5'd1, 5'd1, F3_BEQ));
        prog.push_back(itype_word(12'd1, 5'd5, F3_ADD, 5'd5, OPC_OP_IMM));
        prog.push_back(branch_word(13'd8, 5'd1, 5'd1, F3_BNE));
        prog.push_back(itype_word(12'd1, 5'd6, F3_ADD, 5'd6, OPC_OP_IMM));
        for (int b = 0; b < 2; b++) begin
            draw_bits(7, v);
            prog.push_back(branch_word(13'd8, {2'b00, v[5:3]}, {2'b00, v[2:0]},
                                       v[6] ? F3_BNE : F3_BEQ));
            prog.push_back(itype_word(12'd1, 5'd7, F3_ADD, 5'd7, OPC_OP_IMM));
        end
        end_pc = 32'(4 * prog.size());
        prog.push_back(branch_word(13'd0, 5'd0, 5'd0, F3_BEQ));
    endtask

    // ==============================
    // reference model
    // ==============================
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic [31:0] a,
                                            input logic [31:0] b);
        case (f3)
            F3_XOR:  return a ^ b;
            F3_OR:   return a | b;
            F3_AND:  return a & b;
            default: return a + b;
        endcase
    endfunction

    always_comb begin
        m_insn    = model_mem[model_pc[MEM_IDX_W+1:2]];
        m_rs1v    = model_regs[m_insn[19:15]];
        m_rs2v    = model_regs[m_insn[24:20]];
        m_imm_i   = {{20{m_insn[31]}}, m_insn[31:20]};
        m_imm_s   = {{20{m_insn[31]}}, m_insn[31:25], m_insn[11:7]};
        m_imm_b   = {{20{m_insn[31]}}, m_insn[7], m_insn[30:25], m_insn[11:8], 1'b0};
        m_ld_addr = m_rs1v + m_imm_i;
        m_f3      = m_insn[14:12];
        m_alu_f3  = (m_f3 == F3_ADD) || (m_f3 == F3_XOR) || (m_f3 == F3_OR) || (m_f3 == F3_AND);

        exp_pc      = model_pc;
        exp_rd_idx  = m_insn[11:7];
        exp_rd_we   = 1'b0;
        exp_rd_data = '0;
        exp_store   = 1'b0;
        exp_st_addr = m_rs1v + m_imm_s;
        exp_st_data = m_rs2v;
        exp_next_pc = model_pc + 32'd4;
        case (m_insn[6:0])
            OPC_OP_IMM: begin
                exp_rd_we   = m_alu_f3;
                exp_rd_data = alu_ref(m_f3, m_rs1v, m_imm_i);
            end
            OPC_OP: begin
                if (m_insn[31:25] == F7_SUB && m_f3 == F3_ADD) begin
                    exp_rd_we   = 1'b1;
                    exp_rd_data = m_rs1v - m_rs2v;
                end else if (m_insn[31:25] == F7_BASE) begin
                    exp_rd_we   = m_alu_f3;
                    exp_rd_data = alu_ref(m_f3, m_rs1v, m_rs2v);
                end
            end
            OPC_LOAD: begin
                exp_rd_we   = (m_f3 == F3_LW);
                exp_rd_data = model_mem[m_ld_addr[MEM_IDX_W+1:2]];
            end
            OPC_STORE: exp_store = (m_f3 == F3_SW);
            OPC_BRANCH: begin
                if ((m_f3 == F3_BEQ && m_rs1v == m_rs2v) ||
                    (m_f3 == F3_BNE && m_rs1v != m_rs2v)) begin
                    exp_next_pc = model_pc + m_imm_b;
                end
            end
            OPC_LUI: begin
                exp_rd_we   = 1'b1;
                exp_rd_data = {m_insn[31:12], 12'b0};
            end
            default: ;
        endcase
        exp_rd_we = exp_rd_we && (exp_rd_idx != 5'd0);
    end

    // one architectural step per retire
    always @(posedge sys_clk) begin
        if (sys_rst) begin
            model_pc   <= '0;
            store_seen <= 1'b0;
            for (int i = 0; i < REG_COUNT; i++) begin
                model_regs[i] <= '0;
            end
        end else begin
            if (prog_we && !run) begin
                model_mem[prog_addr] <= prog_data;
            end
            if (mem_we_out) begin
                store_seen <= 1'b1;
            end
            if (retire_valid) begin
                store_seen <= 1'b0;
                if (exp_rd_we) begin
                    model_regs[exp_rd_idx] <= exp_rd_data;
                end
                if (exp_store) begin
                    model_mem[exp_st_addr[MEM_IDX_W+1:2]] <= exp_st_data;
                end
                model_pc <= exp_next_pc;
            end
        end
    end

    // ==============================
    // checks
    // ==============================
    assert property (@(posedge sys_clk) disable iff (sys_rst)
        !run |-> !retire_valid && !rd_we && !mem_we_out)
        else abort_run($sformatf("error: retire_valid %h rd_we %h mem_we_out %h with run low",
                                 $sampled(retire_valid), $sampled(rd_we),
                                 $sampled(mem_we_out)));

    assert property (@(posedge sys_clk) disable iff (sys_rst)
        retire_valid |-> retire_pc == exp_pc)
        else abort_run($sformatf("error: retire_pc %h expected %h",
                                 $sampled(retire_pc), $sampled(exp_pc)));

    assert property (@(posedge sys_clk) disable iff (sys_rst)
        rd_we == (retire_valid && exp_rd_we))
        else abort_run($sformatf("error: rd_we %h expected %h at pc %h", $sampled(rd_we),
                                 $sampled(retire_valid && exp_rd_we), $sampled(exp_pc)));

    assert property (@(posedge sys_clk) disable iff (sys_rst)
        rd_we |-> rd_idx == exp_rd_idx && rd_data == exp_rd_data)
        else abort_run($sformatf("error: rd_idx %h rd_data %h expected %h %h",
                                 $sampled(rd_idx), $sampled(rd_data),
                                 $sampled(exp_rd_idx), $sampled(exp_rd_data)));

    assert property (@(posedge sys_clk) disable iff (sys_rst)
        mem_we_out |-> exp_store && mem_addr_out == exp_st_addr
                       && mem_wdata_out == exp_st_data)
        else abort_run($sformatf("error: mem_addr_out %h mem_wdata_out %h expected %h %h",
                                 $sampled(mem_addr_out), $sampled(mem_wdata_out),
                                 $sampled(exp_st_addr), $sampled(exp_st_data)));

    assert property (@(posedge sys_clk) disable iff (sys_rst)
        retire_valid && exp_store |-> store_seen)
        else abort_run("a store retired without raising mem_we_out");

    task wait_retire(output logic [31:0] pc_seen);
        int  cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 20) begin
            @(negedge sys_clk);
            cycles++;
            seen = retire_valid;
        end
        if (seen) begin
            pc_seen = retire_pc;
        end else begin
            abort_run("timed out waiting for an instruction to retire");
        end
    endtask

    initial begin
        logic [31:0] seen_pc;
        int          guard;
        sys_rst   = 1'b1;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        build_program();
        repeat (4) @(posedge sys_clk);
        sys_rst <= 1'b0;

        for (int i = 0; i < prog.size(); i++) begin
            @(posedge sys_clk);
            prog_we   <= 1'b1;
            prog_addr <= MEM_IDX_W'(i);
            prog_data <= prog[i];
        end
        @(posedge sys_clk);
        prog_we <= 1'b0;
        // idle a few cycles with run low
        repeat (3) @(posedge sys_clk);
        run <= 1'b1;

        guard   = 0;
        seen_pc = '0;
        while (seen_pc != end_pc && guard < 200) begin
            wait_retire(seen_pc);
            guard++;
        end
        if (seen_pc != end_pc) begin
            abort_run("program never reached its final loop");
        end else begin
            repeat (2) wait_retire(seen_pc);
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// ==== unified_mem.sv ====
module unified_mem (
    input  logic                          sys_clk,
    input  logic                          mem_en,
    input  logic                          mem_we,
    input  logic [cpu_pkg::MEM_IDX_W-1:0] mem_idx,
    input  logic [cpu_pkg::XLEN-1:0]      mem_wdata,
    output logic [cpu_pkg::XLEN-1:0]      mem_rdata
);
    import cpu_pkg::*;

    // ==============================
    // word storage
    // ==============================
    logic [XLEN-1:0] words [MEM_WORDS];

    // one access per cycle, read data held until the next read
    always_ff @(posedge sys_clk) begin
        if (mem_en) begin
            if (mem_we) begin
                words[mem_idx] <= mem_wdata;
            end else begin
                mem_rdata <= words[mem_idx];
            end
        end
    end

    assert property (@(posedge sys_clk) mem_we |-> mem_en)
        else $error("unified_mem: write strobe without enable at idx %h", mem_idx);

endmodule
